// File: acc.f
+incdir+.
acc_pkg.sv
glbSram.sv
sipoPacker.sv
pisoUnpacker.sv
glbArbiter.sv
ccuRegs.sv
padInterface.sv
accTop.sv
acc_sva.sv
acc_tb.sv

// File: accTop.sv
// Accelerator data interface top: register block, pad engine, GLB arbiter and GLB
`timescale 1ns/100ps
`include "acc_macros.svh"

module accTop (
    input  logic                   clk,
    input  logic                   rst_n,
    // AXI4-Lite config slave
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic                   rvalid,
    input  logic                   rready,
    // Pad port
    output logic [`ACC_PORT_W-1:0] padOutDat,
    output logic                   padOutVld,
    input  logic                   padOutRdy,
    output logic                   padCmdVld,
    output logic                   padOe,
    input  logic [`ACC_PORT_W-1:0] padInDat,
    input  logic                   padInVld,
    output logic                   padInRdy,
    // Compute-side GLB peer
    input  logic                   peReqVld,
    input  acc_pkg::glbReq_t       peReq,
    output logic                   peGnt,
    output logic                   peRspVld,
    output acc_pkg::glbRsp_t       peRsp
);
    import acc_pkg::*;

    itfCfg_t                cfg;
    logic                   start, xferDone;
    logic                   itfReqVld, itfGnt, itfRspVld, memEn;
    logic [1:0]             arbGnt, arbRspVld;
    glbReq_t                itfReq, memReq;
    glbRsp_t                glbRsp;
    logic [`ACC_SRAM_W-1:0] memRdata;

    // Peer 0 is the pad engine, peer 1 the compute side
    assign itfGnt    = arbGnt[0];
    assign peGnt     = arbGnt[1];
    assign itfRspVld = arbRspVld[0];
    assign peRspVld  = arbRspVld[1];
    assign peRsp     = glbRsp;

    ccuRegs uRegs (
        .clk (clk), .rst_n (rst_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rvalid (rvalid), .rready (rready),
        .cfg (cfg), .start (start), .xferDone (xferDone)
    );

    padInterface uItf (
        .clk (clk), .rst_n (rst_n),
        .cfg (cfg), .start (start), .xferDone (xferDone),
        .padOutDat (padOutDat), .padOutVld (padOutVld), .padOutRdy (padOutRdy),
        .padCmdVld (padCmdVld), .padOe (padOe),
        .padInDat (padInDat), .padInVld (padInVld), .padInRdy (padInRdy),
        .itfReqVld (itfReqVld), .itfReq (itfReq), .itfGnt (itfGnt),
        .itfRspVld (itfRspVld), .itfRsp (glbRsp)
    );

    glbArbiter #(.reqT (glbReq_t)) uArb (
        .clk (clk), .rst_n (rst_n),
        .reqVld ({peReqVld, itfReqVld}), .req ({peReq, itfReq}),
        .gnt (arbGnt), .memEn (memEn), .memReq (memReq),
        .memRdata (memRdata), .rspVld (arbRspVld), .rsp (glbRsp)
    );

    glbSram uGlb (
        .clk (clk), .en (memEn), .we (memReq.we),
        .addr (memReq.addr), .wdata (memReq.wdata), .rdata (memRdata)
    );

endmodule

// File: acc_macros.svh
// Width and ratio definitions shared by the accelerator data interface
`ifndef ACC_MACROS_SVH
`define ACC_MACROS_SVH

// ============================================================
// Datapath widths
// ============================================================

// One pad beat
`define ACC_PORT_W  32
// One GLB word
`define ACC_SRAM_W  64
// GLB word address, 256 entries
`define ACC_GLB_AW  8
// DRAM base address, plus the direction bit fills one pad beat
`define ACC_DRAM_AW 31
// Pad beats per GLB word
`define ACC_RATIO   2

`endif

// File: acc_pkg.sv
// Shared types of the accelerator data interface: config, GLB request and response
`include "acc_macros.svh"

package acc_pkg;

    // Transfer direction, also bit 0 of the command beat
    typedef enum logic {
        DirIn2Chip = 1'b0,
        DirOut2Off = 1'b1
    } xferDir_e;

    // Transfer config from the register block
    typedef struct packed {
        xferDir_e                dir;
        logic [`ACC_DRAM_AW-1:0] dramBase;
        logic [`ACC_GLB_AW-1:0]  glbBase;
        // Length in GLB words
        logic [`ACC_GLB_AW-1:0]  num;
    } itfCfg_t;

    // One GLB access from a peer
    typedef struct packed {
        logic                   we;
        logic [`ACC_GLB_AW-1:0] addr;
        logic [`ACC_SRAM_W-1:0] wdata;
    } glbReq_t;

    // Read data back to a peer
    typedef struct packed {
        logic [`ACC_SRAM_W-1:0] rdata;
    } glbRsp_t;

    // Beat position inside one GLB word
    typedef logic [$clog2(`ACC_RATIO)-1:0] beatIdx_t;

endpackage

// File: acc_sva.sv
// Handshake assertions on the pad engine's pad port and GLB grant
`timescale 1ns/100ps
`include "acc_macros.svh"

module acc_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic [`ACC_PORT_W-1:0] padOutDat,
    input logic                   padOutVld,
    input logic                   padOutRdy,
    input logic                   padCmdVld,
    input logic [`ACC_PORT_W-1:0] padInDat,
    input logic                   padInVld,
    input logic                   padInRdy,
    input logic                   itfReqVld,
    input logic                   itfGnt
);

    // Failure tally, read by the testbench at the end
    int failCnt = 0;

    // ============================================================
    // Pad beats hold until taken
    // ============================================================
    outBeatHeld: assert property (@(posedge clk) disable iff (!rst_n)
        padOutVld && !padOutRdy |=> padOutVld && $stable(padOutDat))
    else begin
        $error("Outbound pad beat dropped or changed before its handshake");
        failCnt++;
    end

    // Off-chip side obeys the same rule
    inBeatHeld: assert property (@(posedge clk) disable iff (!rst_n)
        padInVld && !padInRdy |=> padInVld && $stable(padInDat))
    else begin
        $error("Inbound pad beat dropped or changed before its handshake");
        failCnt++;
    end

    // ============================================================
    // Grant and command qualifiers
    // ============================================================
    gntNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
        itfGnt |-> itfReqVld)
    else begin
        $error("GLB grant to the pad engine without a request");
        failCnt++;
    end

    cmdNeedsVld: assert property (@(posedge clk) disable iff (!rst_n)
        padCmdVld |-> padOutVld)
    else begin
        $error("Command flag raised without a valid pad beat");
        failCnt++;
    end

endmodule

// Attached to every pad engine instance
bind padInterface acc_sva uSva (
    .clk (clk), .rst_n (rst_n),
    .padOutDat (padOutDat), .padOutVld (padOutVld), .padOutRdy (padOutRdy),
    .padCmdVld (padCmdVld),
    .padInDat (padInDat), .padInVld (padInVld), .padInRdy (padInRdy),
    .itfReqVld (itfReqVld), .itfGnt (itfGnt)
);

// File: acc_tb.sv
// Testbench for the accelerator data interface: AXI-Lite, off-chip pad model and GLB peer
`timescale 1ns/100ps
`include "acc_macros.svh"

module acc_tb;
    import acc_pkg::*;

    localparam int CycleLimit = 4000;

    logic                   clk, rst_n;
    logic [3:0]             awaddr, araddr;
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    logic                   arvalid, arready, rvalid, rready;
    logic [31:0]            wdata, rdata;
    logic [`ACC_PORT_W-1:0] padOutDat, padInDat;
    logic                   padOutVld, padOutRdy, padCmdVld, padOe, padInVld, padInRdy;
    logic                   peReqVld, peGnt, peRspVld;
    glbReq_t                peReq;
    glbRsp_t                peRsp;

    // Reference GLB contents, built from the testbench's own writes
    logic [`ACC_SRAM_W-1:0] refMem [2**`ACC_GLB_AW];
    logic [`ACC_PORT_W-1:0] expBeats [$];
    logic [`ACC_PORT_W-1:0] expCmd;
    integer                 seed = 32'he2d87be8;
    int                     errCnt = 0;
    int                     cycles = 0;
    int                     cmdCnt, peRsps = 0;
    int                     inIdx = 0;
    int                     inTotal = 0;
    logic                   rdPend = 1'b0;
    logic [`ACC_GLB_AW-1:0] pendAddr;

    accTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [`ACC_PORT_W-1:0] beatPat(input int i);
        return 32'hBEA7_0000 + 32'(i);
    endfunction

    // Preload word, every address bit shows in both halves
    function automatic logic [`ACC_SRAM_W-1:0] wordPat(input logic [7:0] a);
        return {24'hA11A00, a, 24'h5AA500, a};
    endfunction

    task automatic flagError(input string msg);
        errCnt++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        assert (wready) else flagError("AXI W not accepted together with AW");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge clk);
        assert (bvalid) else flagError("AXI write response not one cycle after accept");
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        @(posedge clk);
        assert (rvalid) else flagError("AXI read data not one cycle after accept");
        data = rdata;
    endtask

    // Back-to-back peer accesses, address steps on each grant
    task automatic peBurst(input logic isWrite, input logic [7:0] base, input int n);
        int i;
        i = 0;
        peReqVld <= 1'b1;
        peReq    <= '{we: isWrite, addr: base, wdata: wordPat(base)};
        while (i < n) begin
            @(posedge clk);
            if (peGnt) begin
                if (isWrite) refMem[peReq.addr] = peReq.wdata;
                i++;
                peReq <= '{we: isWrite, addr: base + 8'(i), wdata: wordPat(base + 8'(i))};
            end
        end
        peReqVld <= 1'b0;
        // Last response lands on the first of these edges
        repeat (2) @(posedge clk);
    endtask

    // One transfer: config, readback, start, status poll
    task automatic runXfer(input xferDir_e dir, input logic [30:0] dram,
                           input logic [7:0] glb, input logic [7:0] num);
        logic [31:0] rd;
        int          firstBeat;
        expCmd    = {dram, dir};
        cmdCnt    = 0;
        firstBeat = inIdx;
        if (dir == DirOut2Off) begin
            for (int i = 0; i < num; i++) begin
                expBeats.push_back(refMem[glb + 8'(i)][31:0]);
                expBeats.push_back(refMem[glb + 8'(i)][63:32]);
            end
        end else begin
            inTotal = inIdx + 2 * num;
        end
        axiWrite(4'h4, {1'b0, dram});
        axiWrite(4'h8, {8'd0, num, 8'd0, glb});
        axiRead(4'h4, rd);
        assert (rd == {1'b0, dram}) else flagError("DRAM base readback mismatch");
        axiRead(4'h8, rd);
        assert (rd == {8'd0, num, 8'd0, glb}) else flagError("GLB base/count readback mismatch");
        axiWrite(4'h0, {30'd0, dir, 1'b1});
        axiRead(4'h0, rd);
        assert (rd == {30'd0, dir, 1'b0}) else flagError("control readback mismatch");
        axiRead(4'hC, rd);
        assert (rd[1:0] == 2'b01) else flagError("status not busy after start");
        do axiRead(4'hC, rd); while (!rd[1]);
        assert (!rd[0]) else flagError("busy still set with done");
        assert (cmdCnt == 1) else flagError("command beat count wrong");
        assert (expBeats.size() == 0) else flagError("outbound beats missing");
        assert (inIdx == inTotal) else flagError("inbound beats not all taken");
        // Packing rule, low beat first
        if (dir == DirIn2Chip) begin
            for (int i = 0; i < num; i++) begin
                refMem[glb + 8'(i)] = {beatPat(firstBeat + 2 * i + 1), beatPat(firstBeat + 2 * i)};
            end
        end
    endtask

    // ============================================================
    // Off-chip pad model and peer read checker
    // ============================================================
    always @(posedge clk) begin
        if (rst_n) begin
            if (padOutVld && padOutRdy) begin
                if (padCmdVld) begin
                    assert (padOutDat == expCmd && padOe) else flagError("command beat wrong");
                    cmdCnt++;
                end else begin
                    assert (expBeats.size() > 0 && padOutDat == expBeats[0] && padOe)
                        else flagError("outbound beat wrong or unexpected");
                    if (expBeats.size() > 0) void'(expBeats.pop_front());
                end
            end
            if (padInVld && padInRdy) inIdx++;
            padOutRdy <= ($random(seed) & 3) != 0;
            // New beat only once the old one is gone
            if (!padInVld || padInRdy) begin
                padInVld <= inIdx < inTotal && ($random(seed) & 3) != 0;
                padInDat <= beatPat(inIdx);
            end
        end
    end

    // Read data one cycle after the grant
    always @(posedge clk) begin
        if (rdPend) begin
            assert (peRspVld && peRsp.rdata == refMem[pendAddr])
                else flagError("peer read data wrong or late");
        end
        // Every peer response, write echoes included
        if (rst_n && peRspVld) begin
            peRsps++;
        end
        rdPend   = rst_n && peReqVld && peGnt && !peReq.we;
        pendAddr = peReq.addr;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Simulation hung: tests did not finish within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int rspsBefore;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        padOutRdy = 1'b0;
        padInDat  = '0;
        padInVld  = 1'b0;
        peReqVld  = 1'b0;
        peReq     = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Preload, then outbound from the preloaded words
        peBurst(1'b1, 8'h40, 48);
        runXfer(DirOut2Off, 31'h1234_5678, 8'h40, 8'd4);
        runXfer(DirIn2Chip, 31'h0ABC_DEF0, 8'h10, 8'd4);
        peBurst(1'b0, 8'h10, 4);
        // Inbound while the compute peer reads nonstop
        rspsBefore = peRsps;
        fork
            runXfer(DirIn2Chip, 31'h7654_3210, 8'h20, 8'd4);
            peBurst(1'b0, 8'h40, 48);
        join
        assert (peRsps == rspsBefore + 48)
            else flagError("peer responses lost or extra under contention");
        peBurst(1'b0, 8'h20, 4);
        $display("Checks failed: %0d, assertion failures: %0d", errCnt, dut.uItf.uSva.failCnt);
        if (errCnt == 0 && dut.uItf.uSva.failCnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: ccuRegs.sv
// AXI4-Lite register block holding the transfer config, start pulse and busy/done status
`timescale 1ns/100ps
`include "acc_macros.svh"

module ccuRegs (
    input  logic              clk,
    input  logic              rst_n,
    // AXI4-Lite write side
    input  logic [3:0]        awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    input  logic              bready,
    // AXI4-Lite read side
    input  logic [3:0]        araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic              rvalid,
    input  logic              rready,
    // Pad interface control
    output acc_pkg::itfCfg_t  cfg,
    output logic              start,
    input  logic              xferDone
);
    import acc_pkg::*;

    itfCfg_t     cfgQ;
    logic        wrEn;
    logic        rdEn;
    logic        busy;
    logic        done;
    logic [31:0] rdMux;

    // AW and W taken together, one outstanding B at a time
    assign wrEn    = awvalid && wvalid && !bvalid;
    assign awready = wrEn;
    assign wready  = wrEn;
    // One outstanding R at a time
    assign rdEn    = arvalid && !rvalid;
    assign arready = rdEn;
    assign cfg     = cfgQ;

    // ============================================================
    // Write decode, start pulse, status
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            start  <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
            cfgQ   <= '0;
        end else begin
            start <= 1'b0;
            if (wrEn) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // Config frozen while a transfer runs
            if (wrEn && !busy) begin
                case (awaddr[3:2])
                    2'd0: begin
                        cfgQ.dir <= xferDir_e'(wdata[1]);
                        start    <= wdata[0];
                    end
                    2'd1: cfgQ.dramBase <= wdata[`ACC_DRAM_AW-1:0];
                    2'd2: begin
                        cfgQ.glbBase <= wdata[`ACC_GLB_AW-1:0];
                        cfgQ.num     <= wdata[16 +: `ACC_GLB_AW];
                    end
                    default: ;
                endcase
            end
            // Done is sticky until the next start
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (xferDone) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ============================================================
    // Read path
    // ============================================================
    always_comb begin
        case (araddr[3:2])
            2'd0:    rdMux = {30'd0, cfgQ.dir, 1'b0};
            2'd1:    rdMux = {1'b0, cfgQ.dramBase};
            2'd2:    rdMux = {8'd0, cfgQ.num, 8'd0, cfgQ.glbBase};
            default: rdMux = {30'd0, done, busy};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rdEn) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read data captured with the address
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdata <= rdMux;
        end
    end

endmodule

// File: glbArbiter.sv
// Round-robin arbiter giving two peers turns on the single-port GLB
`timescale 1ns/100ps
`include "acc_macros.svh"

module glbArbiter #(
    parameter type reqT = logic
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [1:0]             reqVld,
    input  reqT  [1:0]             req,
    output logic [1:0]             gnt,
    output logic                   memEn,
    output reqT                    memReq,
    input  logic [`ACC_SRAM_W-1:0] memRdata,
    output logic [1:0]             rspVld,
    output acc_pkg::glbRsp_t       rsp
);
    import acc_pkg::*;

    // Peer that wins the next conflict
    logic prio;

    always_comb begin
        gnt = 2'b00;
        if (reqVld[0] && (!reqVld[1] || !prio)) begin
            gnt[0] = 1'b1;
        end else if (reqVld[1]) begin
            gnt[1] = 1'b1;
        end
    end

    assign memEn  = |gnt;
    assign memReq = gnt[1] ? req[1] : req[0];
    // Read data goes to both peers, rspVld says whose it is
    assign rsp.rdata = memRdata;

    // Owner of the access registered for the one-cycle read return
    // A write also echoes rspVld, peers ignore it then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio   <= 1'b0;
            rspVld <= 2'b00;
        end else begin
            rspVld <= gnt;
            if (gnt[0]) begin
                prio <= 1'b1;
            end else if (gnt[1]) begin
                prio <= 1'b0;
            end
        end
    end

endmodule

// File: glbSram.sv
// Global buffer: single-port SRAM with one-cycle registered read
`timescale 1ns/100ps
`include "acc_macros.svh"

module glbSram (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [`ACC_GLB_AW-1:0] addr,
    input  logic [`ACC_SRAM_W-1:0] wdata,
    output logic [`ACC_SRAM_W-1:0] rdata
);

    logic [`ACC_SRAM_W-1:0] mem [2**`ACC_GLB_AW];

    // Read data held until the next read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: padInterface.sv
// Pad transfer engine: command beat, then inbound packing or outbound unpacking through the GLB
`timescale 1ns/100ps
`include "acc_macros.svh"

module padInterface (
    input  logic                   clk,
    input  logic                   rst_n,
    input  acc_pkg::itfCfg_t       cfg,
    input  logic                   start,
    output logic                   xferDone,
    // Pad port
    output logic [`ACC_PORT_W-1:0] padOutDat,
    output logic                   padOutVld,
    input  logic                   padOutRdy,
    output logic                   padCmdVld,
    output logic                   padOe,
    input  logic [`ACC_PORT_W-1:0] padInDat,
    input  logic                   padInVld,
    output logic                   padInRdy,
    // GLB peer port
    output logic                   itfReqVld,
    output acc_pkg::glbReq_t       itfReq,
    input  logic                   itfGnt,
    input  logic                   itfRspVld,
    input  acc_pkg::glbRsp_t       itfRsp
);
    import acc_pkg::*;

    typedef enum logic [1:0] {Idle, Cmd, In2Chip, Out2Off} itfState_e;

    itfState_e              state;
    itfState_e              nextState;
    logic [`ACC_GLB_AW-1:0] cnt;
    logic                   rdPend;
    logic                   wrVld, rdVld, inDone, outDone;
    logic                   packInRdy, packVld, unpackInRdy, unpackVld;
    logic [`ACC_SRAM_W-1:0] packDat;
    logic [`ACC_PORT_W-1:0] unpackDat;

    // ============================================================
    // FSM
    // ============================================================
    assign inDone   = state == In2Chip && cnt == cfg.num;
    // Outbound ends once nothing is left in the read stage or the unpacker
    assign outDone  = state == Out2Off && cnt == cfg.num && !rdPend && !unpackVld;
    assign xferDone = inDone || outDone;

    always_comb begin
        nextState = state;
        case (state)
            Idle:    if (start) nextState = Cmd;
            Cmd:     if (padOutRdy) nextState = (cfg.dir == DirOut2Off) ? Out2Off : In2Chip;
            In2Chip: if (inDone) nextState = Idle;
            Out2Off: if (outDone) nextState = Idle;
            default: nextState = Idle;
        endcase
    end

    // Word counter, cleared between transfers; rdPend marks a read in the SRAM stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= Idle;
            cnt    <= '0;
            rdPend <= 1'b0;
        end else begin
            state  <= nextState;
            cnt    <= (state == Idle) ? '0 : cnt + (itfReqVld && itfGnt);
            rdPend <= state == Out2Off && itfReqVld && itfGnt;
        end
    end

    // Command beat: DRAM base above the direction bit
    assign padCmdVld = state == Cmd;
    assign padOe     = state == Cmd || state == Out2Off;
    assign padOutVld = padCmdVld || unpackVld;
    assign padOutDat = padCmdVld ? {cfg.dramBase, cfg.dir} : unpackDat;
    assign padInRdy  = packInRdy && state == In2Chip;

    // ============================================================
    // GLB requests
    // ============================================================
    assign wrVld = state == In2Chip && packVld && cnt < cfg.num;
    // Read only when the word returning next cycle is sure to fit in the unpacker
    assign rdVld = state == Out2Off && cnt < cfg.num && unpackInRdy && !rdPend;
    assign itfReqVld = wrVld || rdVld;

    always_comb begin
        itfReq.we    = state == In2Chip;
        itfReq.addr  = cfg.glbBase + cnt;
        itfReq.wdata = packDat;
    end

    sipoPacker uPacker (
        .clk    (clk),
        .rst_n  (rst_n),
        .inVld  (padInVld && state == In2Chip),
        .inDat  (padInDat),
        .inRdy  (packInRdy),
        .outVld (packVld),
        .outDat (packDat),
        .outRdy (wrVld && itfGnt)
    );

    // Responses after inbound writes are dropped by the state gate
    pisoUnpacker uUnpacker (
        .clk    (clk),
        .rst_n  (rst_n),
        .inVld  (itfRspVld && state == Out2Off),
        .inDat  (itfRsp.rdata),
        .inRdy  (unpackInRdy),
        .outVld (unpackVld),
        .outDat (unpackDat),
        .outRdy (padOutRdy && state == Out2Off)
    );

endmodule

// File: pisoUnpacker.sv
// Parallel-in serial-out unpacker: splits one GLB word into pad beats, low beat first
`timescale 1ns/100ps
`include "acc_macros.svh"

module pisoUnpacker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inVld,
    input  logic [`ACC_SRAM_W-1:0] inDat,
    output logic                   inRdy,
    output logic                   outVld,
    output logic [`ACC_PORT_W-1:0] outDat,
    input  logic                   outRdy
);
    import acc_pkg::*;

    beatIdx_t               beatIdx;
    logic                   lastBeat, take, emit;
    logic [`ACC_SRAM_W-1:0] shReg;

    assign lastBeat = beatIdx == beatIdx_t'(`ACC_RATIO - 1);
    assign emit     = outVld && outRdy;
    // Room when empty or when the last beat leaves this cycle
    assign inRdy    = !outVld || (emit && lastBeat);
    assign take     = inVld && inRdy;
    assign outDat   = shReg[`ACC_PORT_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatIdx <= '0;
            outVld  <= 1'b0;
        end else if (take) begin
            beatIdx <= '0;
            outVld  <= 1'b1;
        end else if (emit) begin
            beatIdx <= lastBeat ? '0 : beatIdx + 1'b1;
            outVld  <= !lastBeat;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shReg <= inDat;
        end else if (emit) begin
            shReg <= shReg >> `ACC_PORT_W;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the accelerator data interface testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module acc_tb -f acc.f -o accSim
./obj_dir/accSim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation passed"

// File: sipoPacker.sv
// Serial-in parallel-out packer: collects pad beats into one GLB word, low beat first
`timescale 1ns/100ps
`include "acc_macros.svh"

module sipoPacker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inVld,
    input  logic [`ACC_PORT_W-1:0] inDat,
    output logic                   inRdy,
    output logic                   outVld,
    output logic [`ACC_SRAM_W-1:0] outDat,
    input  logic                   outRdy
);
    import acc_pkg::*;

    beatIdx_t               beatIdx;
    logic                   lastBeat;
    logic [`ACC_SRAM_W-1:0] shReg;

    // No new beat while a packed word waits for the GLB
    assign inRdy    = !outVld;
    assign lastBeat = beatIdx == beatIdx_t'(`ACC_RATIO - 1);
    assign outDat   = shReg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatIdx <= '0;
            outVld  <= 1'b0;
        end else if (inVld && inRdy) begin
            beatIdx <= lastBeat ? '0 : beatIdx + 1'b1;
            outVld  <= lastBeat;
        end else if (outVld && outRdy) begin
            outVld <= 1'b0;
        end
    end

    // Shift in from the top, first beat ends up lowest
    always_ff @(posedge clk) begin
        if (inVld && inRdy) begin
            shReg <= {inDat, shReg[`ACC_SRAM_W-1:`ACC_PORT_W]};
        end
    end

endmodule
